// ==== filelist.f ====
+incdir+common
common/irq_pkg.sv
common/periph_bus_if.sv
plic/irq_gateway.sv
plic/plic.sv
design/machine_timer.sv
design/periph_bus_decoder.sv
design/periph_irq_top.sv
testbench/tb_clock.sv
testbench/periph_irq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --top-module periph_irq_tb -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vperiph_irq_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
exit 1

// ==== testbench/periph_irq_tb.sv ====
`include "irq_defs.svh"

module periph_irq_tb
    import irq_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 4000;       // About twice the expected run length.

    logic                clk;
    logic                reset;
    logic                bus_en;
    logic [3:0]          bus_we;
    logic [31:0]         bus_addr;
    logic [31:0]         bus_wdata;
    logic [31:0]         bus_rdata;
    logic [`IRQ_COUNT:2] ext_irq;
    logic                iack;
    logic                irq;

    logic [31:0]         lfsr_q;
    int                  cycles;

    // Reference model state.
    logic [63:0]         mtime_m;
    logic [63:0]         cmp_m;
    gate_state_e         gate_m [`IRQ_COUNT:1];
    logic [`IRQ_COUNT:1] pend_m;
    logic [`IRQ_COUNT:1] enable_m;
    logic [`IRQ_COUNT:1] ack_m;
    irq_id_t             claim_m;

    tb_clock clock_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    periph_irq_top periph_irq_top_i (
        .clk         (clk),
        .reset       (reset),
        .bus_en_i    (bus_en),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata),
        .ext_irq_i   (ext_irq),
        .iack_i      (iack),
        .irq_o       (irq)
    );

    // ********************
    // Random numbers
    // ********************

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // ********************
    // Reference model
    // ********************

    function automatic logic [31:0] apply_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] r;
        r = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return r;
    endfunction

    function irq_id_t lowest_active();
        irq_id_t id;
        id = '0;
        for (int i = `IRQ_COUNT; i >= 1; i--) begin
            if (pend_m[i] && enable_m[i]) begin
                id = irq_id_t'(i);
            end
        end
        return id;
    endfunction

    function automatic logic [`IRQ_COUNT:1] id_onehot(input irq_id_t id);
        logic [`IRQ_COUNT:1] v;
        v = '0;
        if (id != '0) begin
            v[id] = 1'b1;
        end
        return v;
    endfunction

    always @(posedge clk) begin : model
        logic [`IRQ_COUNT:1] lines;
        if (reset) begin
            mtime_m  <= '0;
            cmp_m    <= '1;
            pend_m   <= '0;
            enable_m <= '0;
            ack_m    <= '0;
            claim_m  <= '0;
            for (int i = 1; i <= `IRQ_COUNT; i++) begin
                gate_m[i] <= GATE_IDLE;
            end
        end else begin
            lines = {ext_irq, (mtime_m >= cmp_m)};
            for (int i = 1; i <= `IRQ_COUNT; i++) begin
                pend_m[i] <= (gate_m[i] == GATE_PENDING);
                if (gate_m[i] == GATE_IDLE && lines[i]) begin
                    gate_m[i] <= GATE_PENDING;
                end else if (gate_m[i] == GATE_PENDING && ack_m[i]) begin
                    gate_m[i] <= GATE_SERVICE;
                end else if (gate_m[i] == GATE_SERVICE && !lines[i]) begin
                    gate_m[i] <= GATE_IDLE;
                end
            end
            ack_m <= iack ? id_onehot(lowest_active()) : '0;
            if (iack) begin
                claim_m <= lowest_active();
            end
            mtime_m <= mtime_m + 64'd1;
            if (bus_en && bus_we != 4'b0000) begin
                if (bus_addr[31:24] == `PLIC_REGION && bus_addr[23:0] == `PLIC_ENABLE_OFS) begin
                    enable_m <= bus_wdata[`IRQ_COUNT:1];
                end
                if (bus_addr[31:24] == `TIMER_REGION) begin
                    case (bus_addr[23:0])
                        `TMR_TIME_LO_OFS: mtime_m[31:0] <=
                            apply_bytes(mtime_m[31:0] + 32'd1, bus_wdata, bus_we);
                        `TMR_TIME_HI_OFS: mtime_m[63:32] <=
                            apply_bytes(mtime_m[63:32] + {31'd0, &mtime_m[31:0]}, bus_wdata, bus_we);
                        `TMR_CMP_LO_OFS:  cmp_m[31:0] <= apply_bytes(cmp_m[31:0], bus_wdata, bus_we);
                        `TMR_CMP_HI_OFS:  cmp_m[63:32] <= apply_bytes(cmp_m[63:32], bus_wdata, bus_we);
                        default: ;
                    endcase
                end
            end
        end
    end

    function logic [31:0] expected_read(input logic [31:0] a);
        logic [31:0] r;
        r = '0;
        if (a[31:24] == `PLIC_REGION) begin
            case (a[23:0])
                `PLIC_CLAIM_OFS:  r = {{(32-`IRQ_ID_W){1'b0}}, claim_m};
                `PLIC_PEND_OFS:   r = {{(31-`IRQ_COUNT){1'b0}}, pend_m, 1'b0};
                `PLIC_ENABLE_OFS: r = {{(31-`IRQ_COUNT){1'b0}}, enable_m, 1'b0};
                default:          r = '0;
            endcase
        end else if (a[31:24] == `TIMER_REGION) begin
            case (a[23:0])
                `TMR_TIME_LO_OFS: r = mtime_m[31:0];
                `TMR_TIME_HI_OFS: r = mtime_m[63:32];
                `TMR_CMP_LO_OFS:  r = cmp_m[31:0];
                `TMR_CMP_HI_OFS:  r = cmp_m[63:32];
                default:          r = '0;
            endcase
        end
        return r;
    endfunction

    // ********************
    // Compare tasks
    // ********************

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_id(input string name, input irq_id_t got, input irq_id_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_irq(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_ack(input string name, input logic [`IRQ_COUNT:1] got,
                             input logic [`IRQ_COUNT:1] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    // Outputs are checked every cycle, away from the driving edge.
    always @(negedge clk) begin
        if (!reset) begin
            check_irq("irq_o", irq, (|(pend_m & enable_m)) & ~iack);
            check_ack("iack_o", periph_irq_top_i.plic_ack, ack_m);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            report_failure();
        end
    end

    // ********************
    // Bus and core tasks
    // ********************

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] we);
        @(posedge clk);
        bus_en    <= 1'b1;
        bus_we    <= we;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        bus_en    <= 1'b0;
        bus_we    <= 4'b0000;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        logic [31:0] exp;
        @(posedge clk);
        bus_en   <= 1'b1;
        bus_we   <= 4'b0000;
        bus_addr <= addr;
        @(negedge clk);
        exp = expected_read(addr);          // State the DUT samples at the next edge.
        @(posedge clk);
        bus_en <= 1'b0;
        @(negedge clk);
        data = bus_rdata;
        check_data($sformatf("bus_rdata_o[%h]", addr), data, exp);
    endtask

    task automatic pulse_iack();
        @(posedge clk);
        iack <= 1'b1;
        @(posedge clk);
        iack <= 1'b0;
    endtask

    function automatic logic [31:0] plic_addr(input logic [23:0] ofs);
        return {`PLIC_REGION, ofs};
    endfunction

    function automatic logic [31:0] timer_addr(input logic [23:0] ofs);
        return {`TIMER_REGION, ofs};
    endfunction

    // ********************
    // Test sequence
    // ********************

    initial begin : main
        logic [31:0] data;
        logic [31:0] first;
        logic [31:0] mask;
        logic [31:0] target;
        logic [7:0]  region;
        irq_id_t     w;
        bus_en      = 1'b0;
        bus_we      = 4'b0000;
        bus_addr    = '0;
        bus_wdata   = '0;
        ext_irq     = '0;
        iack        = 1'b0;
        lfsr_q      = 32'h86c4;
        cycles      = 0;
        @(negedge clk);
        while (reset) @(negedge clk);

        // After reset.
        bus_read(plic_addr(`PLIC_CLAIM_OFS), data);
        check_data("claim", data, 32'd0);
        bus_read(plic_addr(`PLIC_PEND_OFS), data);
        check_data("pending", data, 32'd0);
        bus_read(plic_addr(`PLIC_ENABLE_OFS), data);
        check_data("enable", data, 32'd0);
        bus_read(timer_addr(`TMR_TIME_LO_OFS), first);
        bus_read(timer_addr(`TMR_TIME_LO_OFS), data);
        if (data <= first) begin
            $display("The mtime low word did not increase between two reads.");
            report_failure();
        end

        // Enable masks and the unmapped region.
        for (int n = 0; n < 16; n++) begin
            mask = take_bits(32);
            bus_write(plic_addr(`PLIC_ENABLE_OFS), mask, 4'hF);
            bus_read(plic_addr(`PLIC_ENABLE_OFS), data);
            check_data("enable readback", data, {23'd0, mask[`IRQ_COUNT:1], 1'b0});
            region = 8'(take_bits(8));
            if (region == `PLIC_REGION || region == `TIMER_REGION) begin
                region = region ^ 8'h40;
            end
            // Same offset as the enable register, so a decode alias would show.
            bus_write({region, `PLIC_ENABLE_OFS}, take_bits(32), 4'hF);
            bus_read({region, `PLIC_ENABLE_OFS}, data);
            check_data("unmapped read", data, 32'd0);
            bus_read(plic_addr(`PLIC_ENABLE_OFS), data);
        end

        // External levels, claims and rearming.
        for (int n = 0; n < 16; n++) begin
            @(posedge clk);
            data = take_bits(`IRQ_COUNT - 1);
            ext_irq <= data[`IRQ_COUNT-2:0];
            bus_write(plic_addr(`PLIC_ENABLE_OFS), take_bits(32), 4'hF);
            repeat (4) @(posedge clk);
            bus_read(plic_addr(`PLIC_PEND_OFS), data);
            @(negedge clk);
            w = lowest_active();
            if (w != '0) begin
                pulse_iack();
                @(negedge clk);
                check_ack("iack_o after pulse", periph_irq_top_i.plic_ack, id_onehot(w));
                bus_read(plic_addr(`PLIC_CLAIM_OFS), data);
                check_id("claim", data[`IRQ_ID_W-1:0], w);
                bus_read(plic_addr(`PLIC_PEND_OFS), data);
                check_irq($sformatf("pending[%0d] after ack", w), data[int'(w)], 1'b0);
                repeat (3) @(posedge clk);
                bus_read(plic_addr(`PLIC_PEND_OFS), data);
                check_irq($sformatf("pending[%0d] held line", w), data[int'(w)], 1'b0);
                if (w >= 2) begin
                    @(posedge clk);
                    ext_irq[int'(w)] <= 1'b0;
                    repeat (3) @(posedge clk);
                    ext_irq[int'(w)] <= 1'b1;
                    repeat (4) @(posedge clk);
                    bus_read(plic_addr(`PLIC_PEND_OFS), data);
                    check_irq($sformatf("pending[%0d] rearmed", w), data[int'(w)], 1'b1);
                end
            end
        end

        // Timer compare as source 1.
        @(posedge clk);
        ext_irq <= '0;
        bus_write(plic_addr(`PLIC_ENABLE_OFS), 32'd0, 4'hF);
        bus_write(timer_addr(`TMR_TIME_HI_OFS), 32'd0, 4'hF);
        bus_read(timer_addr(`TMR_TIME_LO_OFS), data);
        target = data + 32'd24 + take_bits(4);
        bus_write(timer_addr(`TMR_CMP_HI_OFS), 32'd0, 4'hF);
        bus_write(timer_addr(`TMR_CMP_LO_OFS), target, 4'hF);
        data = '0;
        for (int n = 0; n < 64 && !data[1]; n++) begin
            bus_read(plic_addr(`PLIC_PEND_OFS), data);
        end
        if (!data[1]) begin
            $display("The timer interrupt never became pending.");
            report_failure();
        end
        bus_read(timer_addr(`TMR_TIME_LO_OFS), data);
        if (data < target) begin
            $display("The timer interrupt became pending before mtime reached mtimecmp.");
            report_failure();
        end
        bus_write(timer_addr(`TMR_CMP_LO_OFS), 32'hFFFF_FFFF, 4'hF);
        bus_write(timer_addr(`TMR_CMP_HI_OFS), 32'hFFFF_FFFF, 4'hF);
        @(negedge clk);
        check_irq("mtip", periph_irq_top_i.mtip, 1'b0);
        bus_write(plic_addr(`PLIC_ENABLE_OFS), 32'h0000_0002, 4'hF);
        repeat (2) @(posedge clk);
        pulse_iack();
        @(negedge clk);
        check_ack("iack_o timer", periph_irq_top_i.plic_ack, id_onehot(irq_id_t'(1)));
        bus_read(plic_addr(`PLIC_CLAIM_OFS), data);
        check_id("claim timer", data[`IRQ_ID_W-1:0], irq_id_t'(1));

        repeat (4) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;         // 40 ns period.
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;                    // Released on an edge, like the stimulus.
    end

endmodule

// ==== design/periph_irq_top.sv ====
`include "irq_defs.svh"

module periph_irq_top (
    input  logic                    clk,
    input  logic                    reset,

    // Peripheral bus from the core.
    input  logic                    bus_en_i,
    input  logic [3:0]              bus_we_i,
    input  logic [31:0]             bus_addr_i,
    input  logic [31:0]             bus_wdata_i,
    output logic [31:0]             bus_rdata_o,

    // Interrupt lines and core handshake.
    input  logic [`IRQ_COUNT:2]     ext_irq_i,
    input  logic                    iack_i,
    output logic                    irq_o
);

    logic                mtip;
    logic [`IRQ_COUNT:1] raw_lines;
    logic [`IRQ_COUNT:1] gate_req;
    logic [`IRQ_COUNT:1] plic_ack;

    periph_bus_if plic_bus ();
    periph_bus_if timer_bus ();

    assign raw_lines = {ext_irq_i, mtip};      // Timer is source 1.

    periph_bus_decoder decoder_i (
        .clk         (clk),
        .reset       (reset),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .plic_bus    (plic_bus.initiator),
        .timer_bus   (timer_bus.initiator)
    );

    machine_timer timer_i (
        .clk    (clk),
        .reset  (reset),
        .bus    (timer_bus.target),
        .mtip_o (mtip)
    );

    irq_gateway gateway_i (
        .clk         (clk),
        .reset       (reset),
        .irq_lines_i (raw_lines),
        .iack_i      (plic_ack),
        .req_o       (gate_req)
    );

    plic plic_i (
        .clk    (clk),
        .reset  (reset),
        .bus    (plic_bus.target),
        .irq_i  (gate_req),
        .iack_i (iack_i),
        .iack_o (plic_ack),
        .irq_o  (irq_o)
    );

endmodule

// ==== design/periph_bus_decoder.sv ====
`include "irq_defs.svh"

module periph_bus_decoder
    import irq_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic            bus_en_i,
    input  logic [3:0]      bus_we_i,
    input  logic [31:0]     bus_addr_i,
    input  logic [31:0]     bus_wdata_i,
    output logic [31:0]     bus_rdata_o,

    periph_bus_if.initiator plic_bus,
    periph_bus_if.initiator timer_bus
);

    bus_target_e target;
    bus_target_e read_tgt_q;

    always_comb begin
        case (bus_addr_i[31:24])
            `PLIC_REGION:  target = TGT_PLIC;
            `TIMER_REGION: target = TGT_TIMER;
            default:       target = TGT_NONE;
        endcase
    end

    // Strobe goes only to the selected region.
    assign plic_bus.en     = bus_en_i && (target == TGT_PLIC);
    assign plic_bus.we     = bus_we_i;
    assign plic_bus.addr   = bus_addr_i[23:0];
    assign plic_bus.wdata  = bus_wdata_i;

    assign timer_bus.en    = bus_en_i && (target == TGT_TIMER);
    assign timer_bus.we    = bus_we_i;
    assign timer_bus.addr  = bus_addr_i[23:0];
    assign timer_bus.wdata = bus_wdata_i;

    // ********************
    // Read return
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            read_tgt_q <= TGT_NONE;
        end else if (bus_en_i && (bus_we_i == 4'b0000)) begin
            read_tgt_q <= target;               // Writes leave the last read in place.
        end
    end

    always_comb begin
        case (read_tgt_q)
            TGT_PLIC:  bus_rdata_o = plic_bus.rdata;
            TGT_TIMER: bus_rdata_o = timer_bus.rdata;
            default:   bus_rdata_o = '0;
        endcase
    end

    target_excl_a: assert property (@(posedge clk) disable iff (reset)
        !(plic_bus.en && timer_bus.en));

endmodule

// ==== design/machine_timer.sv ====
`include "irq_defs.svh"

module machine_timer (
    input  logic        clk,
    input  logic        reset,

    periph_bus_if.target bus,

    output logic        mtip_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [63:0] mtime_inc;
    logic        bus_wr;
    logic        bus_rd;

    // Replace the bytes selected by be, keep the rest.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign mtime_inc = mtime_q + 64'd1;
    assign bus_wr    = bus.en && (bus.we != 4'b0000);
    assign bus_rd    = bus.en && (bus.we == 4'b0000);

    // ********************
    // Counter and compare
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;                   // Keeps mtip low out of reset.
        end else begin
            mtime_q <= mtime_inc;
            if (bus_wr) begin
                case (bus.addr)
                    `TMR_TIME_LO_OFS: mtime_q[31:0]  <= merge_bytes(mtime_inc[31:0],
                                                                    bus.wdata, bus.we);
                    `TMR_TIME_HI_OFS: mtime_q[63:32] <= merge_bytes(mtime_inc[63:32],
                                                                    bus.wdata, bus.we);
                    `TMR_CMP_LO_OFS:  mtimecmp_q[31:0]  <= merge_bytes(mtimecmp_q[31:0],
                                                                       bus.wdata, bus.we);
                    `TMR_CMP_HI_OFS:  mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32],
                                                                       bus.wdata, bus.we);
                    default: ;
                endcase
            end
        end
    end

    assign mtip_o = (mtime_q >= mtimecmp_q);   // Level, held until cmp moves.

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rdata <= '0;
        end else if (bus_rd) begin
            case (bus.addr)
                `TMR_TIME_LO_OFS: bus.rdata <= mtime_q[31:0];
                `TMR_TIME_HI_OFS: bus.rdata <= mtime_q[63:32];
                `TMR_CMP_LO_OFS:  bus.rdata <= mtimecmp_q[31:0];
                `TMR_CMP_HI_OFS:  bus.rdata <= mtimecmp_q[63:32];
                default:          bus.rdata <= '0;
            endcase
        end
    end

endmodule

// ==== plic/plic.sv ====
`include "irq_defs.svh"

module plic
    import irq_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    periph_bus_if.target            bus,

    input  logic [`IRQ_COUNT:1]     irq_i,
    input  logic                    iack_i,
    output logic [`IRQ_COUNT:1]     iack_o,
    output logic                    irq_o
);

    logic [`IRQ_COUNT:1] pend_q;
    logic [`IRQ_COUNT:1] enable_q;
    logic [`IRQ_COUNT:1] active;
    logic [`IRQ_COUNT:1] ack_next;
    irq_id_t             winner;
    irq_id_t             claim_q;
    logic                bus_wr;
    logic                bus_rd;

    // ********************
    // Pending and winner
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= '0;
        end else begin
            pend_q <= irq_i;                // Gateway requests, one cycle late.
        end
    end

    assign active = pend_q & enable_q;

    // Scan downwards so the lowest active id is the last one written.
    always_comb begin
        winner = '0;
        for (int i = `IRQ_COUNT; i >= 1; i--) begin
            if (active[i]) begin
                winner = irq_id_t'(i);
            end
        end
    end

    assign irq_o = (|active) & ~iack_i;     // Dropped during the ack cycle.

    // ********************
    // Claim and acknowledge
    // ********************

    always_comb begin
        ack_next = '0;
        for (int i = 1; i <= `IRQ_COUNT; i++) begin
            ack_next[i] = iack_i && (winner == irq_id_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            claim_q <= '0;
            iack_o  <= '0;
        end else begin
            iack_o <= ack_next;             // One-hot of the captured id.
            if (iack_i) begin
                claim_q <= winner;
            end
        end
    end

    // ********************
    // Register map
    // ********************

    assign bus_wr = bus.en && (bus.we != 4'b0000);
    assign bus_rd = bus.en && (bus.we == 4'b0000);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q  <= '0;
            bus.rdata <= '0;
        end else begin
            if (bus_wr && (bus.addr == `PLIC_ENABLE_OFS)) begin
                enable_q <= bus.wdata[`IRQ_COUNT:1];
            end
            if (bus_rd) begin
                case (bus.addr)
                    `PLIC_CLAIM_OFS:  bus.rdata <= {{(32-`IRQ_ID_W){1'b0}}, claim_q};
                    `PLIC_PEND_OFS:   bus.rdata <= {{(31-`IRQ_COUNT){1'b0}}, pend_q, 1'b0};
                    `PLIC_ENABLE_OFS: bus.rdata <= {{(31-`IRQ_COUNT){1'b0}}, enable_q, 1'b0};
                    default:          bus.rdata <= '0;
                endcase
            end
        end
    end

    // ********************
    // Checks
    // ********************

    ack_onehot_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0(iack_o));

    // A single iack_i pulse from the core yields a single ack cycle.
    ack_single_a: assert property (@(posedge clk) disable iff (reset)
        (|iack_o) |=> (iack_o == '0));

endmodule

// ==== plic/irq_gateway.sv ====
`include "irq_defs.svh"

module irq_gateway
    import irq_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic [`IRQ_COUNT:1]     irq_lines_i,
    input  logic [`IRQ_COUNT:1]     iack_i,
    output logic [`IRQ_COUNT:1]     req_o
);

    gate_state_e state_q [`IRQ_COUNT:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i <= `IRQ_COUNT; i++) begin
                state_q[i] <= GATE_IDLE;
            end
        end else begin
            for (int i = 1; i <= `IRQ_COUNT; i++) begin
                case (state_q[i])
                    GATE_IDLE: begin
                        if (irq_lines_i[i]) begin
                            state_q[i] <= GATE_PENDING;     // Forward one request.
                        end
                    end
                    GATE_PENDING: begin
                        if (iack_i[i]) begin
                            state_q[i] <= GATE_SERVICE;
                        end
                    end
                    GATE_SERVICE: begin
                        // Rearm only once the level has gone away.
                        if (!irq_lines_i[i]) begin
                            state_q[i] <= GATE_IDLE;
                        end
                    end
                    default: state_q[i] <= GATE_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 1; i <= `IRQ_COUNT; i++) begin
            req_o[i] = (state_q[i] == GATE_PENDING);
        end
    end

    // The controller only acks a source whose request it latched.
    ack_when_pending_a: assert property (@(posedge clk) disable iff (reset)
        (iack_i & ~req_o) == '0);

endmodule

// ==== common/periph_bus_if.sv ====
interface periph_bus_if;

    logic        en;        // Access strobe.
    logic [3:0]  we;        // Byte-write mask, zero for a read.
    logic [23:0] addr;      // Offset inside the region.
    logic [31:0] wdata;
    logic [31:0] rdata;     // Registered, valid the cycle after a read.

    // Decoder side.
    modport initiator (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // Register block side.
    modport target (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== common/irq_pkg.sv ====
`include "irq_defs.svh"

package irq_pkg;

    // ********************
    // Gateway
    // ********************

    // Request life cycle of one interrupt source.
    typedef enum logic [1:0] {
        GATE_IDLE    = 2'd0,    // Waiting for the line to rise.
        GATE_PENDING = 2'd1,    // Request forwarded, not yet acked.
        GATE_SERVICE = 2'd2     // Acked, waiting for the line to drop.
    } gate_state_e;

    // ********************
    // Bus decode
    // ********************

    typedef enum logic [1:0] {
        TGT_NONE  = 2'd0,       // Unmapped region, reads as zero.
        TGT_PLIC  = 2'd1,
        TGT_TIMER = 2'd2
    } bus_target_e;

    // ********************
    // Interrupt ids
    // ********************

    typedef logic [`IRQ_ID_W-1:0] irq_id_t;

endpackage

// ==== common/irq_defs.svh ====
`ifndef IRQ_DEFS_SVH
`define IRQ_DEFS_SVH

// ********************
// Interrupt sources
// ********************

`define IRQ_COUNT       8               // Sources 1 to 8.
`define IRQ_ID_W        4               // Id 0 means no interrupt.

// ********************
// Address map
// ********************

`define PLIC_REGION     8'h0C           // Address bits 31 to 24.
`define TIMER_REGION    8'h02

`define PLIC_CLAIM_OFS  24'h000000      // Read only.
`define PLIC_PEND_OFS   24'h001000      // Read only.
`define PLIC_ENABLE_OFS 24'h002000

`define TMR_CMP_LO_OFS  24'h004000
`define TMR_CMP_HI_OFS  24'h004004
`define TMR_TIME_LO_OFS 24'h00BFF8
`define TMR_TIME_HI_OFS 24'h00BFFC

`endif
